// File: smArith_settings.svh
`ifndef SMARITH_SETTINGS_SVH
`define SMARITH_SETTINGS_SVH

// Operand word is a sign bit on top of the magnitude
`define SMA_WORD 16
`define SMA_MAG  15

// Clock period in ns and reset length in cycles for the testbench
`define SMA_CLK_PERIOD   8
`define SMA_RESET_CYCLES 2

`endif

// File: smArithPkg.sv
`include "smArith_settings.svh"

package smArithPkg;

    typedef logic [`SMA_WORD-1:0] word_t;  // Sign in the top bit
    typedef logic [`SMA_MAG-1:0]  mag_t;

    typedef enum logic [1:0] {
        OP_MUL,
        OP_DIV,
        OP_REM
    } opcode_t;

    typedef enum logic [3:0] {
        IDLE,
        SET,
        CHECKADD,
        ADD,
        FIN
    } mulState_t;

    // Divider steps, one check and one subtract per quotient count
    typedef enum logic [2:0] {
        D_IDLE,
        D_SET,
        D_CHECK,
        D_SUB,
        D_FIN
    } divState_t;

endpackage

// File: adder15.sv
`timescale 1ns/100ps
`include "smArith_settings.svh"

module adder15 (
    input  smArithPkg::mag_t in1,
    input  smArithPkg::mag_t in2,
    input  logic             sub,
    output smArithPkg::mag_t sum,
    output logic             cOut
);
    import smArithPkg::*;

    mag_t               opB;
    logic [`SMA_MAG:0]  carry;

    // Subtraction is in1 plus the inverted in2 plus one
    assign opB      = in2 ^ {`SMA_MAG{sub}};
    assign carry[0] = sub;

    genvar i;
    generate
        for (i = 0; i < `SMA_MAG; i++) begin : bitCell
            assign sum[i]     = in1[i] ^ opB[i] ^ carry[i];
            assign carry[i+1] = (in1[i] & opB[i]) | (carry[i] & (in1[i] ^ opB[i]));
        end
    endgenerate

    assign cOut = carry[`SMA_MAG];  // On a subtract this means in1 >= in2

endmodule

// File: multiply.sv
`timescale 1ns/100ps
`include "smArith_settings.svh"

module multiply (
    input  logic              clk,
    input  logic              nRST,
    input  smArithPkg::word_t INn1,
    input  smArithPkg::word_t INn2,
    input  logic              start,
    output smArithPkg::word_t out,
    output logic              finish
);
    import smArithPkg::*;

    mulState_t state, next;
    logic      nextFinish;
    word_t     nextOut;

    mag_t n1, nextN1;
    mag_t n2, nextN2;
    logic diffSign, nextDiffSign;

    // Product accumulator
    mag_t adderOut;
    mag_t adderSave, nextAdderSave;
    mag_t adderIn, nextAdderIn;

    // Loop counter
    mag_t countOut;
    mag_t countSave, nextCountSave;
    mag_t countIn, nextCountIn;

    logic stopCount;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            finish <= 1'b0;
            out    <= '0;
        end else begin
            state  <= next;
            finish <= nextFinish;
            out    <= nextOut;
        end
    end

    always_ff @(posedge clk) begin
        n1        <= nextN1;
        n2        <= nextN2;
        diffSign  <= nextDiffSign;
        countSave <= nextCountSave;
        countIn   <= nextCountIn;
        adderSave <= nextAdderSave;
        adderIn   <= nextAdderIn;
    end

    always_comb begin : nextStateLogic
        next = state;
        case (state)
            IDLE: if (start) begin
                next = SET;
            end
            SET: begin
                if (INn2[`SMA_MAG-1:0] == '0) begin
                    next = FIN;  // Zero multiplier skips the loop
                end else begin
                    next = CHECKADD;
                end
            end
            CHECKADD: begin
                if (stopCount) begin
                    next = FIN;
                end else begin
                    next = ADD;
                end
            end
            ADD: next = CHECKADD;
            FIN: if (!start) begin
                next = IDLE;
            end
            default: next = IDLE;
        endcase
    end

    adder15 main (.in1(n1), .in2(adderIn), .sub(1'b0), .sum(adderOut), .cOut());

    adder15 count (.in1(countIn), .in2(mag_t'(1)), .sub(1'b0), .sum(countOut), .cOut());

    // Stops once the incremented count has reached |B|
    adder15 compCount (.in1(countOut), .in2(n2), .sub(1'b1), .sum(), .cOut(stopCount));

    always_comb begin : datapath
        nextFinish    = finish;
        nextOut       = out;
        nextN1        = n1;
        nextN2        = n2;
        nextDiffSign  = diffSign;
        nextCountSave = countSave;
        nextCountIn   = countIn;
        nextAdderSave = adderSave;
        nextAdderIn   = adderIn;

        case (state)
            SET: begin
                nextDiffSign  = INn1[`SMA_WORD-1] ^ INn2[`SMA_WORD-1];
                nextN1        = INn1[`SMA_MAG-1:0];
                nextN2        = INn2[`SMA_MAG-1:0];
                nextCountSave = '0;
                nextCountIn   = '0;
                nextAdderSave = '0;
                nextAdderIn   = '0;
            end
            CHECKADD: begin
                nextCountSave = countOut;
                nextAdderSave = adderOut;
            end
            ADD: begin
                nextCountIn = countSave;  // Feed the sums back for the next pass
                nextAdderIn = adderSave;
            end
            FIN: begin
                nextOut    = {diffSign, adderSave};
                nextFinish = 1'b1;
            end
            default: nextFinish = 1'b0;
        endcase
    end

    // finish lingers one cycle into IDLE since it is registered
    assert property (@(posedge clk) disable iff (!nRST)
        finish |-> (state == FIN || $past(state) == FIN))
        else $error("multiply: finish high outside FIN");

    assert property (@(posedge clk) disable iff (!nRST)
        (state == FIN && $fell(start)) |=> (state == IDLE) ##1 !finish)
        else $error("multiply: no clean return to IDLE after start fell");

endmodule

// File: divide.sv
`timescale 1ns/100ps
`include "smArith_settings.svh"

module divide (
    input  logic              clk,
    input  logic              nRST,
    input  smArithPkg::word_t INn1,
    input  smArithPkg::word_t INn2,
    input  logic              start,
    output smArithPkg::word_t quot,
    output smArithPkg::word_t rem,
    output logic              divZero,
    output logic              finish
);
    import smArithPkg::*;

    divState_t state, next;
    logic      nextFinish;
    logic      nextDivZero;
    word_t     nextQuot;
    word_t     nextRem;

    mag_t remMag, nextRemMag;    // Running remainder
    mag_t quotMag, nextQuotMag;
    mag_t divisor, nextDivisor;
    logic quotSign, nextQuotSign;
    logic remSign, nextRemSign;
    logic zeroDiv, nextZeroDiv;

    mag_t subOut;
    mag_t incOut;
    logic remGeDiv;

    adder15 subtract (.in1(remMag), .in2(divisor), .sub(1'b1), .sum(subOut), .cOut(remGeDiv));

    adder15 increment (.in1(quotMag), .in2(mag_t'(1)), .sub(1'b0), .sum(incOut), .cOut());

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state   <= D_IDLE;
            finish  <= 1'b0;
            divZero <= 1'b0;
            quot    <= '0;
            rem     <= '0;
        end else begin
            state   <= next;
            finish  <= nextFinish;
            divZero <= nextDivZero;
            quot    <= nextQuot;
            rem     <= nextRem;
        end
    end

    always_ff @(posedge clk) begin
        remMag   <= nextRemMag;
        quotMag  <= nextQuotMag;
        divisor  <= nextDivisor;
        quotSign <= nextQuotSign;
        remSign  <= nextRemSign;
        zeroDiv  <= nextZeroDiv;
    end

    always_comb begin
        next         = state;
        nextFinish   = finish;
        nextDivZero  = divZero;
        nextQuot     = quot;
        nextRem      = rem;
        nextRemMag   = remMag;
        nextQuotMag  = quotMag;
        nextDivisor  = divisor;
        nextQuotSign = quotSign;
        nextRemSign  = remSign;
        nextZeroDiv  = zeroDiv;

        case (state)
            D_IDLE: begin
                nextFinish  = 1'b0;
                nextDivZero = 1'b0;
                if (start) next = D_SET;
            end
            D_SET: begin
                nextQuotSign = INn1[`SMA_WORD-1] ^ INn2[`SMA_WORD-1];
                nextRemSign  = INn1[`SMA_WORD-1];
                nextRemMag   = INn1[`SMA_MAG-1:0];
                nextDivisor  = INn2[`SMA_MAG-1:0];
                if (INn2[`SMA_MAG-1:0] == '0) begin
                    nextQuotMag = '1;  // Saturated quotient flags the zero divisor
                    nextZeroDiv = 1'b1;
                    next        = D_FIN;
                end else begin
                    nextQuotMag = '0;
                    nextZeroDiv = 1'b0;
                    next        = D_CHECK;
                end
            end
            D_CHECK: begin
                if (remGeDiv) begin
                    next = D_SUB;
                end else begin
                    next = D_FIN;
                end
            end
            D_SUB: begin
                nextRemMag  = subOut;
                nextQuotMag = incOut;
                next        = D_CHECK;
            end
            D_FIN: begin
                nextQuot    = {quotSign, quotMag};
                nextRem     = {remSign, remMag};
                nextDivZero = zeroDiv;
                nextFinish  = 1'b1;
                if (!start) next = D_IDLE;
            end
            default: next = D_IDLE;
        endcase
    end

    assert property (@(posedge clk) disable iff (!nRST) divZero |-> finish)
        else $error("divide: divZero without finish");

endmodule

// File: smArithUnit.sv
`timescale 1ns/100ps

module smArithUnit (
    input  logic                clk,
    input  logic                nRST,
    input  logic                req,
    input  smArithPkg::opcode_t op,
    input  smArithPkg::word_t   a,
    input  smArithPkg::word_t   b,
    output logic                ack,
    output smArithPkg::word_t   result,
    output logic                divZero
);
    import smArithPkg::*;

    opcode_t opLatch;
    logic    busy;
    logic    reqDone;  // req has dropped after ack, waiting for ack to clear
    logic    startMul, startDiv;
    logic    mulFinish, divFinish;
    logic    divByZero;
    word_t   mulOut, divQuot, divRem;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            opLatch <= OP_MUL;
            busy    <= 1'b0;
            reqDone <= 1'b0;
        end else if (!busy) begin
            if (req) begin
                busy    <= 1'b1;
                opLatch <= op;
            end
        end else if (reqDone) begin
            if (!ack) begin
                busy    <= 1'b0;
                reqDone <= 1'b0;
            end
        end else if (ack && !req) begin
            reqDone <= 1'b1;
        end
    end

    // A new req during the tail of the last one must not restart a unit
    assign startMul = busy && req && !reqDone && (opLatch == OP_MUL);
    assign startDiv = busy && req && !reqDone && (opLatch != OP_MUL);

    multiply u_multiply (.clk(clk), .nRST(nRST), .INn1(a), .INn2(b), .start(startMul),
                         .out(mulOut), .finish(mulFinish));

    divide u_divide (.clk(clk), .nRST(nRST), .INn1(a), .INn2(b), .start(startDiv),
                     .quot(divQuot), .rem(divRem), .divZero(divByZero), .finish(divFinish));

    assign ack     = (opLatch == OP_MUL) ? mulFinish : divFinish;
    assign divZero = (opLatch != OP_MUL) && divByZero;

    always_comb begin
        case (opLatch)
            OP_MUL:  result = mulOut;
            OP_REM:  result = divRem;
            default: result = divQuot;
        endcase
    end

    // A unit only starts once the other one has dropped its finish
    assert property (@(posedge clk) disable iff (!nRST)
        !(startMul && divFinish) && !(startDiv && mulFinish))
        else $error("smArithUnit: unit started while the other still finishing");

endmodule

// File: tbSmArith.sv
`timescale 1ns/100ps
`include "smArith_settings.svh"

module tbSmArith;
    import smArithPkg::*;

    localparam int unsigned MAX_CYCLES_PER_TEST = 2 * 32768;  // Worst case loop of either unit
    localparam int unsigned WATCHDOG_MARGIN     = 100;
    localparam logic [31:0] LFSR_SEED           = 32'hf004526a;
    localparam logic [31:0] LFSR_TAPS           = 32'h80200003;

    logic    clk;
    logic    nRST;
    logic    req;
    opcode_t op;
    word_t   a;
    word_t   b;
    logic    ack;
    word_t   result;
    logic    divZero;

    logic [31:0] lfsrState;
    logic        testsLoaded;

    // One entry per line of the test data file
    string   names[$];
    opcode_t ops[$];
    word_t   aVals[$];
    word_t   bVals[$];
    word_t   expResults[$];
    logic    expDivZeros[$];

    smArithUnit u_smArithUnit (
        .clk(clk),
        .nRST(nRST),
        .req(req),
        .op(op),
        .a(a),
        .b(b),
        .ack(ack),
        .result(result),
        .divZero(divZero)
    );

    initial begin
        clk = 1'b0;
        forever #(`SMA_CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic stepLfsr();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) lfsrState = lfsrState ^ LFSR_TAPS;
        return outBit;
    endfunction

    function automatic int unsigned drawBits(int unsigned n);
        int unsigned value;
        value = 0;
        for (int unsigned i = 0; i < n; i++) begin
            value = (value << 1) | int'(stepLfsr());
        end
        return value;
    endfunction

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic loadTests();
        int    fd;
        int    count;
        int    opNum;
        string line;
        string name;
        word_t aIn, bIn, expIn;
        int    dzIn;
        fd = $fopen("smArith_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file smArith_testdata.txt");
            $display("SOME TESTS FAILED");
            $fatal(1, "no test data");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() >= 2 && line.getc(0) != "#") begin  // Skip comments and blanks
                count = $sscanf(line, "%s %d %h %h %h %d", name, opNum, aIn, bIn, expIn, dzIn);
                if (count != 6 || opNum > 2) begin
                    $display("test data line could not be parsed: %s", line);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "bad test data");
                end
                names.push_back(name);
                ops.push_back(opcode_t'(opNum));
                aVals.push_back(aIn);
                bVals.push_back(bIn);
                expResults.push_back(expIn);
                expDivZeros.push_back(dzIn[0]);
            end
        end
        $fclose(fd);
        if (names.size() == 0) begin
            $display("the test data file holds no tests");
            $display("SOME TESTS FAILED");
            $fatal(1, "empty test data");
        end
    endtask

    // One full four-phase transaction with random gaps on both sides of ack
    task automatic runTest(input int idx);
        int unsigned delay;
        int unsigned hold;
        word_t       heldResult;
        logic        heldDivZero;
        delay = drawBits(2);
        hold  = drawBits(2);
        repeat (delay) begin
            @(negedge clk);
            checkFlag({names[idx], " ack before req"}, 1'b0, ack);
        end
        @(negedge clk);
        checkFlag({names[idx], " ack before req"}, 1'b0, ack);
        op  = ops[idx];
        a   = aVals[idx];
        b   = bVals[idx];
        req = 1'b1;

        do @(negedge clk); while (ack !== 1'b1);  // Watchdog catches a missing ack
        checkWord({names[idx], " result"}, expResults[idx], result);
        checkFlag({names[idx], " divZero"}, expDivZeros[idx], divZero);
        heldResult  = result;
        heldDivZero = divZero;

        repeat (hold) begin
            @(negedge clk);
            checkFlag({names[idx], " ack held"}, 1'b1, ack);
            checkWord({names[idx], " result held"}, heldResult, result);
            checkFlag({names[idx], " divZero held"}, heldDivZero, divZero);
        end
        req = 1'b0;
        do @(negedge clk); while (ack !== 1'b0);
    endtask

    initial begin : watchdog
        longint limit;
        wait (testsLoaded);
        limit = longint'(names.size()) * MAX_CYCLES_PER_TEST + WATCHDOG_MARGIN;
        repeat (limit) @(posedge clk);
        $display("timeout: ack never arrived within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        nRST        = 1'b0;
        req         = 1'b0;
        op          = OP_MUL;
        a           = '0;
        b           = '0;
        testsLoaded = 1'b0;
        lfsrState   = LFSR_SEED;

        loadTests();
        testsLoaded = 1'b1;

        repeat (`SMA_RESET_CYCLES) @(negedge clk);
        checkFlag("reset ack", 1'b0, ack);
        checkWord("reset result", '0, result);
        checkFlag("reset divZero", 1'b0, divZero);
        nRST = 1'b1;

        for (int i = 0; i < names.size(); i++) begin
            runTest(i);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
smArithPkg.sv
adder15.sv
multiply.sv
divide.sv
smArithUnit.sv
tbSmArith.sv

// File: Bender.yml
package:
  name: smArith

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - smArithPkg.sv
      - adder15.sv
      - multiply.sv
      - divide.sv
      - smArithUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbSmArith.sv

// File: smArith_testdata.txt
# name opcode(0 mul, 1 div, 2 rem) a b expected divZero
# a, b and expected are sign-magnitude hex words, divZero is 0 or 1
mul_pos_small 0 0003 0005 000F 0
mul_neg_pos 0 8007 0006 802A 0
mul_pos_neg 0 000C 8009 806C 0
mul_neg_neg 0 8011 800A 00AA 0
mul_overflow 0 4000 0003 4000 0
mul_overflow_wide 0 1234 0010 2340 0
mul_zero_b_neg 0 0025 8000 8000 0
mul_zero_b_pos 0 8025 0000 8000 0
mul_zero_a 0 0000 0007 0000 0
mul_big_b 0 0001 7FFF 7FFF 0
mul_wrap 0 00FF 8101 FFFF 0
div_exact 1 0064 0005 0014 0
div_neg 1 8064 0007 800E 0
div_small_a 1 0003 8009 8000 0
div_equal 1 8123 8123 0001 0
div_by_one 1 7FFF 0001 7FFF 0
div_zero 1 0042 0000 7FFF 1
div_zero_neg 1 8042 0000 FFFF 1
div_negzero 1 0010 8000 FFFF 1
rem_basic 2 0064 0007 0002 0
rem_neg_a 2 8064 0007 8002 0
rem_neg_b 2 0064 8007 0002 0
rem_small_a 2 8003 0009 8003 0
rem_exact 2 1000 0010 0000 0
rem_zero 2 8042 0000 8042 1
rem_zero_pos 2 0123 8000 0123 1
alt_mul 0 0012 8003 8036 0
alt_div 1 0012 8003 8006 0
alt_rem 2 8013 0004 8003 0
alt_mul2 0 8013 0004 804C 0
alt_div2 1 0013 0000 7FFF 1
alt_mul3 0 0013 0000 0000 0
